// ==== source/dram_bridge_consts.svh ====
// Sizes shared by the cache-to-DRAM bridge.
// Cache-side and DRAM-side widths, plus the burst geometry derived from them.
`ifndef DRAM_BRIDGE_CONSTS_SVH
`define DRAM_BRIDGE_CONSTS_SVH

`define NUM_CACHE 4
`define ADDR_WIDTH 16        // cache byte address
`define CACHE_DATA_WIDTH 32
`define BLOCK_WORDS 8
`define APP_DATA_WIDTH 64    // one DRAM beat
`define BURST_LEN 2          // beats per app command

`define WORDS_PER_BEAT (`APP_DATA_WIDTH / `CACHE_DATA_WIDTH)
`define BURSTS_PER_BLOCK (`BLOCK_WORDS / (`WORDS_PER_BEAT * `BURST_LEN))
`define BURST_BYTES (`BURST_LEN * `APP_DATA_WIDTH / 8)
// cache index goes above the cache address
`define APP_ADDR_WIDTH (`ADDR_WIDTH + $clog2(`NUM_CACHE))

`endif

// ==== source/cache_dma_pkg.sv ====
// Cache DMA types.
// Cache index, cache word and the block request packet from a cache.
`default_nettype none

`include "dram_bridge_consts.svh"

package cache_dma_pkg;

  typedef logic [$clog2(`NUM_CACHE)-1:0] cache_id_t;

  typedef logic [`CACHE_DATA_WIDTH-1:0] cache_word_t;

  // one block request, addr is block aligned
  typedef struct packed {
    logic write_not_read;
    logic [`ADDR_WIDTH-1:0] addr;
  } dma_pkt_t;

endpackage

`default_nettype wire

// ==== source/dram_app_pkg.sv ====
// DRAM controller app interface types.
// Command encoding, command packet and data beats.
`default_nettype none

`include "dram_bridge_consts.svh"

package dram_app_pkg;

  // controller encoding
  typedef enum logic [2:0] {
    APP_WRITE = 3'b000,
    APP_READ  = 3'b001
  } app_cmd_e;

  typedef struct packed {
    app_cmd_e cmd;
    logic [`APP_ADDR_WIDTH-1:0] addr;
  } app_req_t;

  typedef logic [`APP_DATA_WIDTH-1:0] app_word_t;

  typedef struct packed {
    app_word_t data;
    logic last;              // wdf end flag
  } app_wr_beat_t;

endpackage

`default_nettype wire

// ==== source/rr_arbiter.sv ====
// Round-robin N-to-1 arbiter.
// Forwards one valid input with its index; priority moves past each winner.
`timescale 1ns/1ps
`default_nettype none

`include "dram_bridge_consts.svh"

module rr_arbiter #(
  parameter int NUM_IN = `NUM_CACHE,
  parameter type payload_t = logic
) (
  input  logic clk_i,
  input  logic reset_i,

  input  payload_t [NUM_IN-1:0] data_i,
  input  logic [NUM_IN-1:0] v_i,
  output logic [NUM_IN-1:0] yumi_o,

  output logic v_o,
  output payload_t data_o,
  output cache_dma_pkg::cache_id_t tag_o,
  input  logic yumi_i
);
  import cache_dma_pkg::*;

  cache_id_t ptr_r;  // first index searched

  // walk from lowest to highest priority so the highest one wins last
  always_comb begin
    int cand;
    v_o = 1'b0;
    tag_o = ptr_r;
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      cand = (int'(ptr_r) + i) % NUM_IN;
      if (v_i[cand]) begin
        v_o = 1'b1;
        tag_o = cache_id_t'(cand);
      end
    end
  end

  assign data_o = data_i[tag_o];

  always_comb begin
    yumi_o = '0;
    yumi_o[tag_o] = yumi_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r <= '0;
    end else if (yumi_i) begin
      ptr_r <= (tag_o == cache_id_t'(NUM_IN - 1)) ? '0 : tag_o + 1'b1;  // one past winner
    end
  end

endmodule

`default_nettype wire

// ==== source/dram_req_sequencer.sv ====
// DRAM request sequencer.
// Takes one arbitrated block request and issues one app command per burst,
// starting the write or read path as each command is accepted.
`timescale 1ns/1ps
`default_nettype none

`include "dram_bridge_consts.svh"

module dram_req_sequencer (
  input  logic clk_i,
  input  logic reset_i,

  input  logic pkt_v_i,
  input  cache_dma_pkg::dma_pkt_t pkt_i,
  input  cache_dma_pkg::cache_id_t pkt_tag_i,
  output logic pkt_yumi_o,

  output logic app_en_o,
  output dram_app_pkg::app_req_t app_req_o,
  input  logic app_rdy_i,

  output logic wr_start_o,
  output logic rd_start_o,
  output cache_dma_pkg::cache_id_t burst_tag_o,
  input  logic wr_ready_i,
  input  logic rd_ready_i
);
  import cache_dma_pkg::*;
  import dram_app_pkg::*;

  localparam int CNT_W = (`BURSTS_PER_BLOCK > 1) ? $clog2(`BURSTS_PER_BLOCK) : 1;
  localparam logic [`ADDR_WIDTH-1:0] ADDR_STEP = `BURST_BYTES;

  typedef enum logic {
    IDLE,
    SEND
  } seq_state_e;

  seq_state_e state_r;
  cache_id_t tag_r;
  logic [`ADDR_WIDTH-1:0] addr_r;
  logic write_not_read_r;
  logic [CNT_W-1:0] cnt_r;   // bursts issued so far
  logic path_ready;
  logic accept;
  logic last_burst;

  assign pkt_yumi_o = (state_r == IDLE) & pkt_v_i;
  assign path_ready = write_not_read_r ? wr_ready_i : rd_ready_i;
  assign app_en_o = (state_r == SEND) & path_ready;
  assign accept = app_en_o & app_rdy_i;
  assign last_burst = (cnt_r == CNT_W'(`BURSTS_PER_BLOCK - 1));

  assign app_req_o.cmd = write_not_read_r ? APP_WRITE : APP_READ;
  assign app_req_o.addr = {tag_r, addr_r};

  assign wr_start_o = accept & write_not_read_r;
  assign rd_start_o = accept & ~write_not_read_r;
  assign burst_tag_o = tag_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      cnt_r <= '0;
      write_not_read_r <= 1'b0;
      tag_r <= '0;
    end else begin
      case (state_r)
        IDLE: begin
          if (pkt_v_i) begin
            state_r <= SEND;
            cnt_r <= '0;
            write_not_read_r <= pkt_i.write_not_read;
            tag_r <= pkt_tag_i;
          end
        end
        SEND: begin
          if (accept) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_burst) begin
              state_r <= IDLE;
            end
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_yumi_o) begin
      addr_r <= pkt_i.addr;
    end else if (accept) begin
      addr_r <= addr_r + ADDR_STEP;  // next burst
    end
  end

endmodule

`default_nettype wire

// ==== source/dram_write_path.sv ====
// DRAM write path.
// Packs cache words from the tagged cache into app beats and sends one burst
// of beats on the write-data FIFO per start pulse.
`timescale 1ns/1ps
`default_nettype none

`include "dram_bridge_consts.svh"

module dram_write_path (
  input  logic clk_i,
  input  logic reset_i,

  input  logic start_i,
  input  cache_dma_pkg::cache_id_t tag_i,
  output logic ready_o,

  input  cache_dma_pkg::cache_word_t [`NUM_CACHE-1:0] dma_data_i,
  input  logic [`NUM_CACHE-1:0] dma_data_v_i,
  output logic [`NUM_CACHE-1:0] dma_data_yumi_o,

  output logic app_wdf_wren_o,
  output dram_app_pkg::app_wr_beat_t app_wdf_o,
  input  logic app_wdf_rdy_i
);
  import cache_dma_pkg::*;
  import dram_app_pkg::*;

  localparam int HALF_W = (`WORDS_PER_BEAT > 1) ? $clog2(`WORDS_PER_BEAT) : 1;
  localparam int BEAT_W = (`BURST_LEN > 1) ? $clog2(`BURST_LEN) : 1;

  logic busy_r;
  logic full_r;              // beat register waiting on wdf
  cache_id_t tag_r;
  logic [HALF_W-1:0] half_r;
  logic [BEAT_W-1:0] beat_cnt_r;
  app_word_t beat_r;
  logic take;
  logic send;
  logic last_half;
  logic last_beat;

  assign ready_o = ~busy_r;
  assign take = busy_r & ~full_r & dma_data_v_i[tag_r];
  assign send = full_r & app_wdf_rdy_i;
  assign last_half = (half_r == HALF_W'(`WORDS_PER_BEAT - 1));
  assign last_beat = (beat_cnt_r == BEAT_W'(`BURST_LEN - 1));

  always_comb begin
    dma_data_yumi_o = '0;
    dma_data_yumi_o[tag_r] = take;
  end

  assign app_wdf_wren_o = full_r;
  assign app_wdf_o.data = beat_r;
  assign app_wdf_o.last = last_beat;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      full_r <= 1'b0;
      tag_r <= '0;
      half_r <= '0;
      beat_cnt_r <= '0;
    end else begin
      if (start_i) begin
        busy_r <= 1'b1;
        tag_r <= tag_i;
        half_r <= '0;
        beat_cnt_r <= '0;
      end
      if (take) begin
        half_r <= last_half ? '0 : half_r + 1'b1;
        if (last_half) begin
          full_r <= 1'b1;
        end
      end
      if (send) begin
        full_r <= 1'b0;
        beat_cnt_r <= last_beat ? '0 : beat_cnt_r + 1'b1;
        if (last_beat) begin
          busy_r <= 1'b0;  // burst done
        end
      end
    end
  end

  // lowest word lands in the low half
  always_ff @(posedge clk_i) begin
    if (take) begin
      beat_r[half_r*`CACHE_DATA_WIDTH +: `CACHE_DATA_WIDTH] <= dma_data_i[tag_r];
    end
  end

endmodule

`default_nettype wire

// ==== source/dram_read_path.sv ====
// DRAM read path.
// Queues the cache tag of each read burst, buffers returned beats and
// unpacks them, low word first, to the cache at the head of the tag queue.
`timescale 1ns/1ps
`default_nettype none

`include "dram_bridge_consts.svh"

module dram_read_path (
  input  logic clk_i,
  input  logic reset_i,

  input  logic start_i,
  input  cache_dma_pkg::cache_id_t tag_i,
  output logic ready_o,

  input  logic app_rd_data_valid_i,
  input  dram_app_pkg::app_word_t app_rd_data_i,
  input  logic app_rd_data_end_i,

  output cache_dma_pkg::cache_word_t [`NUM_CACHE-1:0] dma_data_o,
  output logic [`NUM_CACHE-1:0] dma_data_v_o,
  input  logic [`NUM_CACHE-1:0] dma_data_ready_i
);
  import cache_dma_pkg::*;
  import dram_app_pkg::*;

  localparam int TAG_DEPTH = 2;
  localparam int TPTR_W = $clog2(TAG_DEPTH);
  localparam int BEAT_DEPTH = 2 * `BURST_LEN;  // every outstanding burst fits
  localparam int BPTR_W = $clog2(BEAT_DEPTH);
  localparam int HALF_W = (`WORDS_PER_BEAT > 1) ? $clog2(`WORDS_PER_BEAT) : 1;

  typedef struct packed {
    logic last;
    app_word_t data;
  } rd_beat_t;

  cache_id_t tag_mem [TAG_DEPTH];
  logic [TPTR_W-1:0] tag_wptr_r;
  logic [TPTR_W-1:0] tag_rptr_r;
  logic [$clog2(TAG_DEPTH+1)-1:0] tag_cnt_r;

  rd_beat_t beat_mem [BEAT_DEPTH];
  logic [BPTR_W-1:0] beat_wptr_r;
  logic [BPTR_W-1:0] beat_rptr_r;
  logic [BPTR_W:0] beat_cnt_r;
  logic [HALF_W-1:0] word_sel_r;

  cache_id_t head_tag;
  rd_beat_t head_beat;
  cache_word_t head_word;
  logic out_v;
  logic xfer;
  logic beat_pop;
  logic tag_pop;

  function automatic logic [BPTR_W-1:0] bump(input logic [BPTR_W-1:0] p);
    return (p == BPTR_W'(BEAT_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ready_o = (tag_cnt_r != TAG_DEPTH);
  assign head_tag = tag_mem[tag_rptr_r];
  assign head_beat = beat_mem[beat_rptr_r];
  assign head_word = head_beat.data[word_sel_r*`CACHE_DATA_WIDTH +: `CACHE_DATA_WIDTH];

  assign out_v = (beat_cnt_r != '0) & (tag_cnt_r != '0);
  assign xfer = out_v & dma_data_ready_i[head_tag];
  assign beat_pop = xfer & (word_sel_r == HALF_W'(`WORDS_PER_BEAT - 1));
  assign tag_pop = beat_pop & head_beat.last;  // burst fully delivered

  // data goes to every port, only the head cache sees valid
  always_comb begin
    dma_data_v_o = '0;
    dma_data_v_o[head_tag] = out_v;
    for (int i = 0; i < `NUM_CACHE; i++) begin
      dma_data_o[i] = head_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_wptr_r <= '0;
      tag_rptr_r <= '0;
      tag_cnt_r <= '0;
      beat_wptr_r <= '0;
      beat_rptr_r <= '0;
      beat_cnt_r <= '0;
      word_sel_r <= '0;
    end else begin
      if (start_i) begin
        tag_wptr_r <= tag_wptr_r + 1'b1;
      end
      if (tag_pop) begin
        tag_rptr_r <= tag_rptr_r + 1'b1;
      end
      case ({start_i, tag_pop})
        2'b10: tag_cnt_r <= tag_cnt_r + 1'b1;
        2'b01: tag_cnt_r <= tag_cnt_r - 1'b1;
        default: ;
      endcase

      if (app_rd_data_valid_i) begin
        beat_wptr_r <= bump(beat_wptr_r);
      end
      if (beat_pop) begin
        beat_rptr_r <= bump(beat_rptr_r);
      end
      case ({app_rd_data_valid_i, beat_pop})
        2'b10: beat_cnt_r <= beat_cnt_r + 1'b1;
        2'b01: beat_cnt_r <= beat_cnt_r - 1'b1;
        default: ;
      endcase

      if (xfer) begin
        word_sel_r <= beat_pop ? '0 : word_sel_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      tag_mem[tag_wptr_r] <= tag_i;
    end
    if (app_rd_data_valid_i) begin
      beat_mem[beat_wptr_r] <= '{last: app_rd_data_end_i, data: app_rd_data_i};
    end
  end

endmodule

`default_nettype wire

// ==== source/cache_to_dram_bridge.sv ====
// Cache-to-DRAM bridge top level.
// Arbitrates block requests from several caches onto one DRAM app interface.
`timescale 1ns/1ps
`default_nettype none

`include "dram_bridge_consts.svh"

module cache_to_dram_bridge (
  input  logic clk_i,
  input  logic reset_i,

  input  cache_dma_pkg::dma_pkt_t [`NUM_CACHE-1:0] dma_pkt_i,
  input  logic [`NUM_CACHE-1:0] dma_pkt_v_i,
  output logic [`NUM_CACHE-1:0] dma_pkt_yumi_o,

  output cache_dma_pkg::cache_word_t [`NUM_CACHE-1:0] dma_data_o,
  output logic [`NUM_CACHE-1:0] dma_data_v_o,
  input  logic [`NUM_CACHE-1:0] dma_data_ready_i,

  input  cache_dma_pkg::cache_word_t [`NUM_CACHE-1:0] dma_data_i,
  input  logic [`NUM_CACHE-1:0] dma_data_v_i,
  output logic [`NUM_CACHE-1:0] dma_data_yumi_o,

  output logic app_en_o,
  input  logic app_rdy_i,
  output dram_app_pkg::app_req_t app_req_o,

  output logic app_wdf_wren_o,
  input  logic app_wdf_rdy_i,
  output dram_app_pkg::app_wr_beat_t app_wdf_o,

  input  logic app_rd_data_valid_i,
  input  dram_app_pkg::app_word_t app_rd_data_i,
  input  logic app_rd_data_end_i
);
  import cache_dma_pkg::*;

  logic arb_v;
  dma_pkt_t arb_pkt;
  cache_id_t arb_tag;
  logic arb_yumi;

  cache_id_t burst_tag;
  logic wr_start;
  logic rd_start;
  logic wr_ready;
  logic rd_ready;

  rr_arbiter #(
    .NUM_IN(`NUM_CACHE),
    .payload_t(dma_pkt_t)
  ) arb (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(dma_pkt_i),
    .v_i(dma_pkt_v_i),
    .yumi_o(dma_pkt_yumi_o),
    .v_o(arb_v),
    .data_o(arb_pkt),
    .tag_o(arb_tag),
    .yumi_i(arb_yumi)
  );

  dram_req_sequencer seq (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pkt_v_i(arb_v),
    .pkt_i(arb_pkt),
    .pkt_tag_i(arb_tag),
    .pkt_yumi_o(arb_yumi),
    .app_en_o(app_en_o),
    .app_req_o(app_req_o),
    .app_rdy_i(app_rdy_i),
    .wr_start_o(wr_start),
    .rd_start_o(rd_start),
    .burst_tag_o(burst_tag),
    .wr_ready_i(wr_ready),
    .rd_ready_i(rd_ready)
  );

  dram_write_path wr_path (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .start_i(wr_start),
    .tag_i(burst_tag),
    .ready_o(wr_ready),
    .dma_data_i(dma_data_i),
    .dma_data_v_i(dma_data_v_i),
    .dma_data_yumi_o(dma_data_yumi_o),
    .app_wdf_wren_o(app_wdf_wren_o),
    .app_wdf_o(app_wdf_o),
    .app_wdf_rdy_i(app_wdf_rdy_i)
  );

  dram_read_path rd_path (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .start_i(rd_start),
    .tag_i(burst_tag),
    .ready_o(rd_ready),
    .app_rd_data_valid_i(app_rd_data_valid_i),
    .app_rd_data_i(app_rd_data_i),
    .app_rd_data_end_i(app_rd_data_end_i),
    .dma_data_o(dma_data_o),
    .dma_data_v_o(dma_data_v_o),
    .dma_data_ready_i(dma_data_ready_i)
  );

endmodule

`default_nettype wire

// ==== tests/tb_cache_to_dram_bridge.sv ====
// Testbench for the cache-to-DRAM bridge.
// Drives four caches with scripted block requests and models the DRAM
// controller with a sparse memory. Commands, write beats and read words are
// compared with values derived from the bridge's mapping rules.
`timescale 1ns/1ps
`default_nettype none

`include "dram_bridge_consts.svh"

module tb_cache_to_dram_bridge;
  import cache_dma_pkg::*;
  import dram_app_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int BLOCKS = 8;                 // blocks per cache
  localparam int TOTAL_BLOCKS = `NUM_CACHE * BLOCKS;
  localparam int RD_DELAY = 4;
  localparam int AW = `APP_ADDR_WIDTH;
  localparam int WPB = `WORDS_PER_BEAT;
  localparam int BEATS_PER_BLOCK = `BLOCK_WORDS / WPB;
  localparam int BEAT_BYTES = `APP_DATA_WIDTH / 8;
  localparam int WORD_BYTES = `CACHE_DATA_WIDTH / 8;
  localparam int CW = `CACHE_DATA_WIDTH;

  logic clk_i = 1'b0;
  logic reset_i;
  dma_pkt_t [`NUM_CACHE-1:0] dma_pkt_i;
  logic [`NUM_CACHE-1:0] dma_pkt_v_i;
  logic [`NUM_CACHE-1:0] dma_pkt_yumi_o;
  cache_word_t [`NUM_CACHE-1:0] dma_data_o;
  logic [`NUM_CACHE-1:0] dma_data_v_o;
  logic [`NUM_CACHE-1:0] dma_data_ready_i;
  cache_word_t [`NUM_CACHE-1:0] dma_data_i;
  logic [`NUM_CACHE-1:0] dma_data_v_i;
  logic [`NUM_CACHE-1:0] dma_data_yumi_o;
  logic app_en_o;
  logic app_rdy_i;
  app_req_t app_req_o;
  logic app_wdf_wren_o;
  logic app_wdf_rdy_i;
  app_wr_beat_t app_wdf_o;
  logic app_rd_data_valid_i;
  app_word_t app_rd_data_i;
  logic app_rd_data_end_i;

  integer seed;
  dma_pkt_t script [`NUM_CACHE][BLOCKS];
  int next_blk [`NUM_CACHE];
  cache_id_t rr_ptr;                         // expected arbiter priority
  cache_word_t wr_q [`NUM_CACHE][$];         // words each cache still has to hand over
  cache_word_t ref_mem [logic [AW-1:0]];     // what the caches wrote
  cache_word_t dram_mem [logic [AW-1:0]];    // controller model storage
  app_req_t exp_req_q [$];
  app_wr_beat_t exp_beat_q [$];
  cache_word_t exp_rd_word_q [$];
  cache_id_t exp_rd_id_q [$];

  logic [AW-1:0] wr_cmd_q [$];
  logic [AW-1:0] rd_cmd_q [$];
  longint rd_time_q [$];
  int rd_dep_q [$];                          // writes that must land before this read
  app_word_t rd_data_q [$];                  // beats read out in command order
  int rd_snap;                               // reads whose data is already taken
  int wr_issued;
  int wr_done;
  int wr_beat;
  int rd_beat;
  longint cycle;

  cache_to_dram_bridge dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input cache_word_t got, input cache_word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_req(input string name, input app_req_t got, input app_req_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_beat(input string name, input app_wr_beat_t got, input app_wr_beat_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input string name, input cache_id_t got, input cache_id_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // fixed pattern for memory nobody has written
  function automatic cache_word_t fill_word(input logic [AW-1:0] a);
    return (cache_word_t'(a) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
  endfunction

  // expected word at a cache address, cache index sits above it in DRAM
  function automatic cache_word_t ref_word(input cache_id_t id, input logic [`ADDR_WIDTH-1:0] addr);
    logic [AW-1:0] a;
    a = {id, addr};
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return fill_word(a);
  endfunction

  function automatic cache_word_t mem_word(input logic [AW-1:0] a);
    if (dram_mem.exists(a)) begin
      return dram_mem[a];
    end
    return fill_word(a);
  endfunction

  // first requester at or after the priority pointer
  function automatic cache_id_t expected_winner(input logic [`NUM_CACHE-1:0] v, input cache_id_t ptr);
    int idx;
    for (int i = 0; i < `NUM_CACHE; i++) begin
      idx = (int'(ptr) + i) % `NUM_CACHE;
      if (v[idx]) begin
        return cache_id_t'(idx);
      end
    end
    return ptr;
  endfunction

  function automatic bit all_done();
    for (int c = 0; c < `NUM_CACHE; c++) begin
      if (next_blk[c] < BLOCKS || wr_q[c].size() != 0) begin
        return 1'b0;
      end
    end
    return exp_req_q.size() == 0 && exp_beat_q.size() == 0 && exp_rd_word_q.size() == 0
        && rd_cmd_q.size() == 0 && wr_cmd_q.size() == 0;
  endfunction

  // cache drivers, they also record what each accepted block must produce
  always @(posedge clk_i) begin
    int g;
    dma_pkt_t pkt;
    app_req_t req;
    app_wr_beat_t beat;
    logic [`ADDR_WIDTH-1:0] baddr;
    cache_word_t words [`BLOCK_WORDS];
    if (reset_i) begin
      rr_ptr = '0;
      for (int c = 0; c < `NUM_CACHE; c++) begin
        next_blk[c] = 0;
      end
    end else begin
      for (int c = 0; c < `NUM_CACHE; c++) begin
        if (dma_data_yumi_o[c]) begin
          if (!dma_data_v_i[c]) begin
            $display("write data taken from cache %0d while it offered none", c);
            abort_run();
          end
          void'(wr_q[c].pop_front());
        end
      end
      if (dma_pkt_yumi_o != '0) begin
        if (!$onehot(dma_pkt_yumi_o)) begin
          $display("request yumi given to more than one cache");
          abort_run();
        end
        g = 0;
        for (int c = 0; c < `NUM_CACHE; c++) begin
          if (dma_pkt_yumi_o[c]) begin
            g = c;
          end
        end
        check_id("dma_pkt_yumi_o index", cache_id_t'(g), expected_winner(dma_pkt_v_i, rr_ptr));
        rr_ptr = cache_id_t'((g + 1) % `NUM_CACHE);
        pkt = dma_pkt_i[g];
        for (int k = 0; k < `BURSTS_PER_BLOCK; k++) begin
          baddr = pkt.addr + k * `BURST_BYTES;
          req.cmd = pkt.write_not_read ? APP_WRITE : APP_READ;
          req.addr = {cache_id_t'(g), baddr};
          exp_req_q.push_back(req);
        end
        for (int w = 0; w < `BLOCK_WORDS; w++) begin
          baddr = pkt.addr + w * WORD_BYTES;
          if (pkt.write_not_read) begin
            words[w] = $random(seed);
            wr_q[g].push_back(words[w]);
            ref_mem[{cache_id_t'(g), baddr}] = words[w];
          end else begin
            exp_rd_word_q.push_back(ref_word(cache_id_t'(g), baddr));
            exp_rd_id_q.push_back(cache_id_t'(g));
          end
        end
        if (pkt.write_not_read) begin
          for (int b = 0; b < BEATS_PER_BLOCK; b++) begin
            for (int h = 0; h < WPB; h++) begin
              beat.data[h*CW +: CW] = words[b*WPB + h];  // low word in low half
            end
            beat.last = (b % `BURST_LEN) == `BURST_LEN - 1;
            exp_beat_q.push_back(beat);
          end
        end
        next_blk[g]++;
      end
      for (int c = 0; c < `NUM_CACHE; c++) begin
        dma_pkt_v_i[c] <= next_blk[c] < BLOCKS;
        dma_pkt_i[c] <= script[c][(next_blk[c] < BLOCKS) ? next_blk[c] : 0];
        dma_data_v_i[c] <= wr_q[c].size() != 0;
        dma_data_i[c] <= (wr_q[c].size() != 0) ? wr_q[c][0] : '0;
        dma_data_ready_i[c] <= ($random(seed) & 3) != 0;
      end
      app_rdy_i <= ($random(seed) & 3) != 0;
      app_wdf_rdy_i <= ($random(seed) & 3) != 0;
    end
  end

  // DRAM controller model, read data after a fixed delay and in command order
  always @(posedge clk_i) begin
    logic [AW-1:0] a;
    app_word_t rd_word;
    if (reset_i) begin
      cycle = 0;
      wr_issued = 0;
      wr_done = 0;
      wr_beat = 0;
      rd_beat = 0;
      rd_snap = 0;
      app_rd_data_valid_i <= 1'b0;
      app_rd_data_end_i <= 1'b0;
    end else begin
      cycle++;
      if (app_en_o && app_rdy_i) begin
        if (app_req_o.cmd == APP_WRITE) begin
          wr_cmd_q.push_back(app_req_o.addr);
          wr_issued++;
        end else begin
          rd_cmd_q.push_back(app_req_o.addr);
          rd_time_q.push_back(cycle + RD_DELAY);
          rd_dep_q.push_back(wr_issued);
        end
      end
      if (app_wdf_wren_o && app_wdf_rdy_i) begin
        if (wr_cmd_q.size() == 0) begin
          $display("write data beat arrived with no write command pending");
          abort_run();
        end
        a = wr_cmd_q[0] + wr_beat * BEAT_BYTES;
        for (int h = 0; h < WPB; h++) begin
          dram_mem[a + h * WORD_BYTES] = app_wdf_o.data[h*CW +: CW];
        end
        if (wr_beat == `BURST_LEN - 1) begin
          wr_beat = 0;
          wr_done++;
          void'(wr_cmd_q.pop_front());
        end else begin
          wr_beat++;
        end
      end
      // a read sees every older write and none of the younger ones
      while (rd_snap < rd_cmd_q.size() && wr_done >= rd_dep_q[rd_snap]) begin
        for (int b = 0; b < `BURST_LEN; b++) begin
          a = rd_cmd_q[rd_snap] + b * BEAT_BYTES;
          for (int h = 0; h < WPB; h++) begin
            rd_word[h*CW +: CW] = mem_word(a + h * WORD_BYTES);
          end
          rd_data_q.push_back(rd_word);
        end
        rd_snap++;
      end
      app_rd_data_valid_i <= 1'b0;
      app_rd_data_end_i <= 1'b0;
      if (rd_cmd_q.size() != 0 && cycle >= rd_time_q[0] && rd_snap > 0) begin
        app_rd_data_valid_i <= 1'b1;
        app_rd_data_i <= rd_data_q.pop_front();
        app_rd_data_end_i <= rd_beat == `BURST_LEN - 1;
        if (rd_beat == `BURST_LEN - 1) begin
          rd_beat = 0;
          rd_snap--;
          void'(rd_cmd_q.pop_front());
          void'(rd_time_q.pop_front());
          void'(rd_dep_q.pop_front());
        end else begin
          rd_beat++;
        end
      end
    end
  end

  // compares commands, write beats and read words
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (app_en_o && app_rdy_i) begin
        if (exp_req_q.size() == 0) begin
          $display("app command issued with no block pending");
          abort_run();
        end
        check_req("app_req_o", app_req_o, exp_req_q.pop_front());
      end
      if (app_wdf_wren_o && app_wdf_rdy_i) begin
        if (exp_beat_q.size() == 0) begin
          $display("write data beat sent with no write block pending");
          abort_run();
        end
        check_beat("app_wdf_o", app_wdf_o, exp_beat_q.pop_front());
      end
      if ($countones(dma_data_v_o) > 1) begin
        $display("read valid raised to more than one cache at once");
        abort_run();
      end
      for (int c = 0; c < `NUM_CACHE; c++) begin
        if (dma_data_v_o[c] && dma_data_ready_i[c]) begin
          if (exp_rd_word_q.size() == 0) begin
            $display("read word delivered to cache %0d with none expected", c);
            abort_run();
          end
          check_id("dma_data_v_o index", cache_id_t'(c), exp_rd_id_q.pop_front());
          check_word($sformatf("dma_data_o[%0d]", c), dma_data_o[c], exp_rd_word_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(TOTAL_BLOCKS * 200 * CLK_PERIOD);
    $display("watchdog expired before all blocks completed");
    abort_run();
  end

  initial begin
    seed = 32'h6812_6730;
    reset_i = 1'b1;
    dma_pkt_i = '0;
    dma_pkt_v_i = '0;
    dma_data_ready_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    app_rdy_i = 1'b0;
    app_wdf_rdy_i = 1'b0;
    app_rd_data_valid_i = 1'b0;
    app_rd_data_i = '0;
    app_rd_data_end_i = 1'b0;
    for (int c = 0; c < `NUM_CACHE; c++) begin
      for (int b = 0; b < BLOCKS; b++) begin
        script[c][b].write_not_read = $random(seed) & 1;
        script[c][b].addr = ($random(seed) & 3) * `BLOCK_WORDS * WORD_BYTES;
      end
      script[c][0] = '{write_not_read: 1'b1, addr: 16'h0040};  // same block in every cache
      script[c][1] = '{write_not_read: 1'b0, addr: 16'h0040};
    end
    repeat (5) @(posedge clk_i);
    if (app_en_o !== 1'b0 || app_wdf_wren_o !== 1'b0 || dma_pkt_yumi_o !== '0
        || dma_data_yumi_o !== '0 || dma_data_v_o !== '0) begin
      $display("bridge outputs not idle during reset");
      abort_run();
    end
    reset_i <= 1'b0;
    while (!all_done()) begin
      @(posedge clk_i);
    end
    repeat (20) @(posedge clk_i);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/cache_dma_pkg.sv
source/dram_app_pkg.sv
source/rr_arbiter.sv
source/dram_req_sequencer.sv
source/dram_write_path.sv
source/dram_read_path.sv
source/cache_to_dram_bridge.sv
tests/tb_cache_to_dram_bridge.sv

// ==== Bender.yml ====
package:
  name: cache_to_dram_bridge

sources:
  - target: any(rtl, test)
    include_dirs:
      - source
    files:
      - source/cache_dma_pkg.sv
      - source/dram_app_pkg.sv
      - source/rr_arbiter.sv
      - source/dram_req_sequencer.sv
      - source/dram_write_path.sv
      - source/dram_read_path.sv
      - source/cache_to_dram_bridge.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_cache_to_dram_bridge.sv
